// ==== common/ahb_pkg.sv ====
//////////////////////////////
// AHB-Lite transfer type, size and response encodings
// Byte-enable decode for a 32-bit data bus
//////////////////////////////
`default_nettype none

package ahb_pkg;

  //////////////////////////////
  // Bus encodings
  //////////////////////////////

  // HTRANS
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // HSIZE, nothing wider than a word on this bus
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  // Slave always answers OKAY
  localparam logic HRESP_OKAY = 1'b0;

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  // Lanes touched by a transfer of this size at this byte offset
  // Anything above a word counts as a full word
  function automatic logic [3:0] gen_be(input hsize_t hsize, input logic [1:0] addr_lsb);
    logic [3:0] be;
    case (hsize)
      HSIZE_BYTE:  be = 4'b0001 << addr_lsb;
      // Halfword offset is forced to an even lane
      HSIZE_HWORD: be = 4'b0011 << {addr_lsb[1], 1'b0};
      default:     be = 4'b1111;
    endcase
    return be;
  endfunction

endpackage

`default_nettype wire

// ==== common/mpram_pkg.sv ====
//////////////////////////////
// Memory word geometry and word/lane union
//////////////////////////////
`default_nettype none

package mpram_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  // Data bus and storage width
  localparam int DATA_W = 32;

  // One enable per byte lane
  localparam int BE_W = DATA_W / 8;

  // Address bits below the word index
  localparam int BYTE_ADDR_LSB = $clog2(BE_W);

  //////////////////////////////
  // Memory word
  //////////////////////////////

  // Same bits seen two ways
  // Whole word for ports and storage, lanes for byte merges
  typedef union packed {
    logic [DATA_W-1:0]      word;
    logic [BE_W-1:0][7:0]   lane;
  } mem_word_t;

endpackage

`default_nettype wire

// ==== common/mpram_port_if.sv ====
//////////////////////////////
// Front-end to memory core link
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

interface mpram_port_if #(
  parameter int MEM_DEPTH = 64
) ();

  import mpram_pkg::*;

  // Word address width
  localparam int AW = $clog2(MEM_DEPTH);

  // Write path, strobe is one cycle per write
  logic              we;
  logic [BE_W-1:0]   be;
  logic [AW-1:0]     waddr;
  logic [DATA_W-1:0] wdata;

  // Read path, data follows the address by one clock
  logic [AW-1:0]     raddr;
  logic [DATA_W-1:0] rdata;

  // Bus front-end side
  modport port (
    output we, be, waddr, wdata, raddr,
    input  rdata
  );

  // Memory side
  modport mem (
    input  we, be, waddr, wdata, raddr,
    output rdata
  );

endinterface

`default_nettype wire

// ==== mpram/ahb_port_ctrl.sv ====
//////////////////////////////
// AHB-Lite slave front-end for one memory port
// Address capture, byte enables, contention stall
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module ahb_port_ctrl #(
  parameter int MEM_DEPTH = 64
) (
  input  wire                          HCLK,
  input  wire                          HRESETn,

  // AHB-Lite slave
  input  wire                          hsel,
  input  wire [31:0]                   haddr,
  input  wire [mpram_pkg::DATA_W-1:0]  hwdata,
  input  wire                          hwrite,
  input  wire ahb_pkg::hsize_t         hsize,
  input  wire ahb_pkg::htrans_t        htrans,
  input  wire                          hready,
  output logic [mpram_pkg::DATA_W-1:0] hrdata,
  output logic                         hreadyout,
  output logic                         hresp,

  // To the memory core
  mpram_port_if.port                   mem
);

  import ahb_pkg::*;
  import mpram_pkg::*;

  //////////////////////////////
  // Declarations
  //////////////////////////////

  localparam int AW = $clog2(MEM_DEPTH);

  // Address phase decode
  logic            xfer_active;
  logic            wr_accept;
  logic            rd_accept;
  logic [AW-1:0]   haddr_word;

  // Pending write, lives for the data phase
  logic            we_q;
  logic [BE_W-1:0] be_q;
  logic [AW-1:0]   waddr_q;

  // Read address kept for the stall cycle
  logic [AW-1:0]   raddr_q;

  logic            stall_req;
  logic            hreadyout_q;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // NONSEQ and SEQ count, IDLE and BUSY do not
  assign xfer_active = hsel & hready &
                       ((htrans == HTRANS_NONSEQ) | (htrans == HTRANS_SEQ));
  assign wr_accept   = xfer_active & hwrite;
  assign rd_accept   = xfer_active & ~hwrite;

  // Word index, byte offset dropped
  assign haddr_word  = haddr[BYTE_ADDR_LSB +: AW];

  // Write strobe for the data phase only
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we_q <= 1'b0;
    end else begin
      we_q <= wr_accept;
    end
  end

  // Lanes and word of the accepted write
  always_ff @(posedge HCLK) begin
    if (wr_accept) begin
      be_q    <= gen_be(hsize, haddr[BYTE_ADDR_LSB-1:0]);
      waddr_q <= haddr_word;
    end
  end

  always_ff @(posedge HCLK) begin
    if (rd_accept) begin
      raddr_q <= haddr_word;
    end
  end

  //////////////////////////////
  // Contention
  //////////////////////////////

  // Read of the word our own write is still landing in
  // A full word is forwarded by the core, a partial one is not
  assign stall_req = rd_accept & we_q & (haddr_word == waddr_q) & ~(&be_q);

  // One wait state, then the merged word is in storage
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hreadyout_q <= 1'b1;
    end else begin
      hreadyout_q <= ~stall_req;
    end
  end

  //////////////////////////////
  // Memory side
  //////////////////////////////

  assign mem.we    = we_q;
  assign mem.be    = be_q;
  assign mem.waddr = waddr_q;
  // HWDATA is valid now, in the data phase
  assign mem.wdata = hwdata;

  // Straight from the bus, except in the wait state
  // There the stalled read is issued again
  assign mem.raddr = hreadyout_q ? haddr_word : raddr_q;

  //////////////////////////////
  // AHB response
  //////////////////////////////

  assign hrdata    = mem.rdata;
  assign hreadyout = hreadyout_q;
  assign hresp     = HRESP_OKAY;

endmodule

`default_nettype wire

// ==== mpram/mpram_core.sv ====
//////////////////////////////
// Shared memory array, two write and two read paths
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module mpram_core #(
  parameter int MEM_DEPTH = 64
) (
  input wire        HCLK,
  input wire        HRESETn,

  // Port 0 has lane priority on a collision
  mpram_port_if.mem p0,
  mpram_port_if.mem p1
);

  import mpram_pkg::*;

  //////////////////////////////
  // Declarations
  //////////////////////////////

  // Storage with contents undefined after reset
  mem_word_t mem_array [MEM_DEPTH];

  // Write data seen as lanes
  mem_word_t wd0;
  mem_word_t wd1;
  mem_word_t wd1_merged;

  // Both ports write the same word this cycle
  logic      collide;

  // Same-port full-word forward
  logic      fwd0;
  logic      fwd1;

  //////////////////////////////
  // Write merge
  //////////////////////////////

  assign wd0.word = p0.wdata;
  assign wd1.word = p1.wdata;

  assign collide = p0.we & p1.we & (p0.waddr == p1.waddr);

  // Port 1 data with port 0 lanes laid over it
  // Both ports then store identical bytes in shared lanes
  always_comb begin
    wd1_merged = wd1;
    for (int i = 0; i < BE_W; i++) begin
      if (collide && p0.be[i]) begin
        wd1_merged.lane[i] = wd0.lane[i];
      end
    end
  end

  // One byte-lane write per enabled lane
  always_ff @(posedge HCLK) begin
    for (int i = 0; i < BE_W; i++) begin
      if (p0.we && p0.be[i]) begin
        mem_array[p0.waddr].lane[i] <= wd0.lane[i];
      end
      if (p1.we && p1.be[i]) begin
        mem_array[p1.waddr].lane[i] <= wd1_merged.lane[i];
      end
    end
  end

  //////////////////////////////
  // Read paths
  //////////////////////////////

  // Own write covers the whole word and is taken before it lands
  // No forward across ports so the other port sees old data this cycle
  assign fwd0 = p0.we & (&p0.be) & (p0.waddr == p0.raddr);
  assign fwd1 = p1.we & (&p1.be) & (p1.waddr == p1.raddr);

  // Registered read data valid the cycle after raddr
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      p0.rdata <= '0;
      p1.rdata <= '0;
    end else begin
      p0.rdata <= fwd0 ? wd0.word : mem_array[p0.raddr].word;
      p1.rdata <= fwd1 ? wd1.word : mem_array[p1.raddr].word;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ahb_mpram_top.sv ====
//////////////////////////////
// Dual-port AHB-Lite SRAM top level
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module ahb_mpram_top #(
  parameter int MEM_DEPTH = 64
) (
  input  wire                          HCLK,
  input  wire                          HRESETn,

  //////////////////////////////
  // AHB-Lite port 0
  //////////////////////////////
  input  wire                          hsel_0,
  input  wire [31:0]                   haddr_0,
  input  wire [mpram_pkg::DATA_W-1:0]  hwdata_0,
  input  wire                          hwrite_0,
  input  wire ahb_pkg::hsize_t         hsize_0,
  input  wire ahb_pkg::htrans_t        htrans_0,
  input  wire                          hready_0,
  output logic [mpram_pkg::DATA_W-1:0] hrdata_0,
  output logic                         hreadyout_0,
  output logic                         hresp_0,

  //////////////////////////////
  // AHB-Lite port 1
  //////////////////////////////
  input  wire                          hsel_1,
  input  wire [31:0]                   haddr_1,
  input  wire [mpram_pkg::DATA_W-1:0]  hwdata_1,
  input  wire                          hwrite_1,
  input  wire ahb_pkg::hsize_t         hsize_1,
  input  wire ahb_pkg::htrans_t        htrans_1,
  input  wire                          hready_1,
  output logic [mpram_pkg::DATA_W-1:0] hrdata_1,
  output logic                         hreadyout_1,
  output logic                         hresp_1
);

  // One link per port into the core
  mpram_port_if #(.MEM_DEPTH(MEM_DEPTH)) p0_if ();
  mpram_port_if #(.MEM_DEPTH(MEM_DEPTH)) p1_if ();

  // Port 0 front-end
  ahb_port_ctrl #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_port0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel_0),
    .haddr     (haddr_0),
    .hwdata    (hwdata_0),
    .hwrite    (hwrite_0),
    .hsize     (hsize_0),
    .htrans    (htrans_0),
    .hready    (hready_0),
    .hrdata    (hrdata_0),
    .hreadyout (hreadyout_0),
    .hresp     (hresp_0),
    .mem       (p0_if.port)
  );

  // Port 1 front-end
  ahb_port_ctrl #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_port1 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel_1),
    .haddr     (haddr_1),
    .hwdata    (hwdata_1),
    .hwrite    (hwrite_1),
    .hsize     (hsize_1),
    .htrans    (htrans_1),
    .hready    (hready_1),
    .hrdata    (hrdata_1),
    .hreadyout (hreadyout_1),
    .hresp     (hresp_1),
    .mem       (p1_if.port)
  );

  // Shared array, port 0 wins lane collisions
  mpram_core #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_core (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .p0      (p0_if.mem),
    .p1      (p1_if.mem)
  );

endmodule

`default_nettype wire

// ==== sim/tb_ahb_mpram.sv ====
//////////////////////////////
// Testbench for the dual-port AHB-Lite SRAM
// Transfer table, byte reference model, timeouts
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module tb_ahb_mpram;

  import ahb_pkg::*;

  localparam int MEM_DEPTH  = 64;
  localparam int WAIT_LIMIT = 20;
  localparam int TBL_MAX    = 64;

  // Transfer kinds
  localparam int K_NORM  = 0;
  localparam int K_IDLE  = 1;
  localparam int K_BUSY  = 2;
  localparam int K_NOSEL = 3;

  // Port 2 means both ports write one word in the same cycle
  // Chain puts the next entry's address phase in this data phase
  typedef struct packed {
    int          port;
    int          wr;
    hsize_t      size;
    logic [31:0] addr;
    logic [31:0] data;
    int          kind;
    int          chain;
    int          stall;
  } entry_t;

  logic        HCLK = 1'b0;
  logic        HRESETn;
  logic        hsel_0, hwrite_0, hready_0, hreadyout_0, hresp_0;
  logic        hsel_1, hwrite_1, hready_1, hreadyout_1, hresp_1;
  logic [31:0] haddr_0, hwdata_0, hrdata_0;
  logic [31:0] haddr_1, hwdata_1, hrdata_1;
  hsize_t      hsize_0, hsize_1;
  htrans_t     htrans_0, htrans_1;

  entry_t      tbl [0:TBL_MAX-1];
  int          n_ent;
  int          seed;
  logic [7:0]  ref_mem [0:4*MEM_DEPTH-1];

  // One slave per bus, so HREADY is its own HREADYOUT
  assign hready_0 = hreadyout_0;
  assign hready_1 = hreadyout_1;

  ahb_mpram_top #(.MEM_DEPTH(MEM_DEPTH)) ahb_mpram_top_inst (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .hsel_0 (hsel_0), .haddr_0 (haddr_0), .hwdata_0 (hwdata_0), .hwrite_0 (hwrite_0),
    .hsize_0 (hsize_0), .htrans_0 (htrans_0), .hready_0 (hready_0),
    .hrdata_0 (hrdata_0), .hreadyout_0 (hreadyout_0), .hresp_0 (hresp_0),
    .hsel_1 (hsel_1), .haddr_1 (haddr_1), .hwdata_1 (hwdata_1), .hwrite_1 (hwrite_1),
    .hsize_1 (hsize_1), .htrans_1 (htrans_1), .hready_1 (hready_1),
    .hrdata_1 (hrdata_1), .hreadyout_1 (hreadyout_1), .hresp_1 (hresp_1)
  );

  always #10 HCLK = ~HCLK;

  //////////////////////////////
  // Checks and reference model
  //////////////////////////////

  task automatic stop_failed();
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, expected);
      stop_failed();
    end
  endtask

  // Lane k is written by a transfer of this size at this byte offset
  function automatic logic lane_on(input hsize_t sz, input logic [1:0] off, input int k);
    case (sz)
      HSIZE_BYTE:  return k == int'(off);
      HSIZE_HWORD: return (k / 2) == int'(off[1]);
      default:     return 1'b1;
    endcase
  endfunction

  function automatic int word_base(input logic [31:0] a);
    return int'((a >> 2) % MEM_DEPTH) * 4;
  endfunction

  task automatic store_ref(input logic [31:0] a, input hsize_t sz, input logic [31:0] d);
    for (int k = 0; k < 4; k++) begin
      if (lane_on(sz, a[1:0], k)) ref_mem[word_base(a) + k] = d[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] expected_word(input logic [31:0] a);
    int b;
    b = word_base(a);
    return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
  endfunction

  //////////////////////////////
  // Bus drivers
  //////////////////////////////

  task automatic drive_addr(input int p, input logic sel, input htrans_t tr, input logic wr,
                            input hsize_t sz, input logic [31:0] a);
    if (p == 0) begin
      hsel_0   = sel;
      htrans_0 = tr;
      hwrite_0 = wr;
      hsize_0  = sz;
      haddr_0  = a;
    end else begin
      hsel_1   = sel;
      htrans_1 = tr;
      hwrite_1 = wr;
      hsize_1  = sz;
      haddr_1  = a;
    end
  endtask

  task automatic idle_port(input int p);
    drive_addr(p, 1'b0, HTRANS_IDLE, 1'b0, HSIZE_WORD, 32'h0);
  endtask

  task automatic drive_wdata(input int p, input logic [31:0] d);
    if (p == 0) hwdata_0 = d;
    else hwdata_1 = d;
  endtask

  function automatic logic ready_of(input int p);
    return (p == 0) ? hreadyout_0 : hreadyout_1;
  endfunction

  // Sampled 1 ns after the edge, so the value holds until the next edge
  task automatic wait_ready(input int p);
    int n;
    n = 0;
    while (!ready_of(p)) begin
      n++;
      if (n > WAIT_LIMIT) begin
        $display("Timed out waiting for hreadyout on port %0d", p);
        stop_failed();
      end
      @(posedge HCLK);
      #1;
    end
  endtask

  //////////////////////////////
  // Table runners
  //////////////////////////////

  // Pipelined run of chained entries on one port
  task automatic run_chain(input int first, output int last);
    int cur;
    int p;
    int stalls;
    cur = first;
    p = tbl[cur].port;
    drive_addr(p, 1'b1, HTRANS_NONSEQ, tbl[cur].wr != 0, tbl[cur].size, tbl[cur].addr);
    wait_ready(p);
    forever begin
      @(posedge HCLK);
      #1;
      // Data phase of cur
      if (tbl[cur].wr != 0) begin
        drive_wdata(p, tbl[cur].data);
        store_ref(tbl[cur].addr, tbl[cur].size, tbl[cur].data);
      end
      if (tbl[cur].chain != 0) begin
        drive_addr(p, 1'b1, HTRANS_NONSEQ, tbl[cur+1].wr != 0, tbl[cur+1].size,
                   tbl[cur+1].addr);
      end else begin
        idle_port(p);
      end
      // Wait states of this data phase
      stalls = 0;
      while (!ready_of(p)) begin
        stalls++;
        if (stalls > WAIT_LIMIT) begin
          $display("Data phase on port %0d never completed", p);
          stop_failed();
        end
        @(posedge HCLK);
        #1;
      end
      check_val(stalls, tbl[cur].stall, $sformatf("entry %0d wait states", cur));
      // OKAY is encoded as 0
      check_val({31'd0, (p == 0) ? hresp_0 : hresp_1}, 32'd0,
                $sformatf("entry %0d hresp", cur));
      if (tbl[cur].wr == 0) begin
        check_val((p == 0) ? hrdata_0 : hrdata_1, expected_word(tbl[cur].addr),
                  $sformatf("entry %0d port %0d read of %h", cur, p, tbl[cur].addr));
      end
      if (tbl[cur].chain == 0) break;
      cur++;
    end
    @(posedge HCLK);
    #1;
    last = cur;
  endtask

  // Port 0 uses the entry size, port 1 writes the inverted word
  task automatic dual_write(input int i);
    drive_addr(0, 1'b1, HTRANS_NONSEQ, 1'b1, tbl[i].size, tbl[i].addr);
    drive_addr(1, 1'b1, HTRANS_NONSEQ, 1'b1, HSIZE_WORD, tbl[i].addr);
    wait_ready(0);
    wait_ready(1);
    @(posedge HCLK);
    #1;
    drive_wdata(0, tbl[i].data);
    drive_wdata(1, ~tbl[i].data);
    idle_port(0);
    idle_port(1);
    // Port 1 fills the word, port 0 lanes land on top
    store_ref(tbl[i].addr, HSIZE_WORD, ~tbl[i].data);
    store_ref(tbl[i].addr, tbl[i].size, tbl[i].data);
    @(posedge HCLK);
    #1;
  endtask

  // IDLE, BUSY or unselected write that must leave memory unchanged
  task automatic ignored_write(input int i);
    htrans_t tr;
    if (tbl[i].kind == K_IDLE) tr = HTRANS_IDLE;
    else if (tbl[i].kind == K_BUSY) tr = HTRANS_BUSY;
    else tr = HTRANS_NONSEQ;
    drive_addr(tbl[i].port, tbl[i].kind != K_NOSEL, tr, 1'b1, HSIZE_WORD, tbl[i].addr);
    @(posedge HCLK);
    #1;
    drive_wdata(tbl[i].port, tbl[i].data);
    idle_port(tbl[i].port);
    @(posedge HCLK);
    #1;
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic add(input int port, input int wr, input hsize_t size, input logic [31:0] addr,
                     input logic [31:0] data, input int kind, input int chain, input int stall);
    tbl[n_ent] = '{port, wr, size, addr, data, kind, chain, stall};
    n_ent++;
  endtask

  task automatic build_table();
    // Filler words 0x00 to 0x3c on alternating ports
    for (int w = 0; w < 16; w++) begin
      add(w % 2, 1, HSIZE_WORD, 32'(w * 4), $random(seed), K_NORM, 0, 0);
    end
    // Word write and read back on each port
    add(0, 1, HSIZE_WORD,  32'h40, 32'hA5A5_0F0F, K_NORM, 0, 0);
    add(0, 0, HSIZE_WORD,  32'h40, 32'h0,         K_NORM, 0, 0);
    add(1, 1, HSIZE_WORD,  32'h44, 32'h1234_5678, K_NORM, 0, 0);
    add(1, 0, HSIZE_WORD,  32'h44, 32'h0,         K_NORM, 0, 0);
    // Bytes and halfwords at each lane offset
    add(0, 1, HSIZE_BYTE,  32'h01, 32'h4433_2211, K_NORM, 0, 0);
    add(0, 1, HSIZE_BYTE,  32'h03, 32'h8877_6655, K_NORM, 0, 0);
    add(1, 1, HSIZE_BYTE,  32'h00, 32'hCCBB_AA99, K_NORM, 0, 0);
    add(1, 1, HSIZE_BYTE,  32'h02, 32'h1F2E_3D4C, K_NORM, 0, 0);
    add(0, 0, HSIZE_WORD,  32'h00, 32'h0,         K_NORM, 0, 0);
    add(1, 1, HSIZE_HWORD, 32'h06, 32'hBEEF_1357, K_NORM, 0, 0);
    add(1, 0, HSIZE_WORD,  32'h04, 32'h0,         K_NORM, 0, 0);
    add(0, 1, HSIZE_HWORD, 32'h08, 32'h2468_ACE0, K_NORM, 0, 0);
    add(0, 0, HSIZE_WORD,  32'h08, 32'h0,         K_NORM, 0, 0);
    // Full word then a forwarded read of it on each port
    add(1, 1, HSIZE_WORD,  32'h0C, 32'hFACE_B00C, K_NORM, 1, 0);
    add(1, 0, HSIZE_WORD,  32'h0C, 32'h0,         K_NORM, 0, 0);
    add(0, 1, HSIZE_WORD,  32'h10, 32'hC0DE_1234, K_NORM, 1, 0);
    add(0, 0, HSIZE_WORD,  32'h10, 32'h0,         K_NORM, 0, 0);
    // Partial write then read of the same word with one wait state
    add(0, 1, HSIZE_BYTE,  32'h15, 32'h0000_5A00, K_NORM, 1, 0);
    add(0, 0, HSIZE_WORD,  32'h14, 32'h0,         K_NORM, 0, 1);
    add(1, 1, HSIZE_HWORD, 32'h1A, 32'h7E7E_0000, K_NORM, 1, 0);
    add(1, 0, HSIZE_WORD,  32'h18, 32'h0,         K_NORM, 0, 1);
    add(0, 1, HSIZE_BYTE,  32'h1C, 32'h0000_00C3, K_NORM, 1, 0);
    add(0, 0, HSIZE_WORD,  32'h20, 32'h0,         K_NORM, 0, 0);
    // Longer pipeline with a stall in the middle
    add(1, 1, HSIZE_BYTE,  32'h23, 32'h9600_0000, K_NORM, 1, 0);
    add(1, 0, HSIZE_WORD,  32'h20, 32'h0,         K_NORM, 1, 1);
    add(1, 0, HSIZE_WORD,  32'h1C, 32'h0,         K_NORM, 1, 0);
    add(1, 1, HSIZE_WORD,  32'h24, $random(seed), K_NORM, 1, 0);
    add(1, 0, HSIZE_WORD,  32'h24, 32'h0,         K_NORM, 0, 0);
    // Cross-port visibility and same-cycle collisions
    add(0, 1, HSIZE_WORD,  32'h28, 32'h5EED_CAFE, K_NORM, 0, 0);
    add(1, 0, HSIZE_WORD,  32'h28, 32'h0,         K_NORM, 0, 0);
    add(2, 1, HSIZE_BYTE,  32'h2D, 32'h0000_9900, K_NORM, 0, 0);
    add(0, 0, HSIZE_WORD,  32'h2C, 32'h0,         K_NORM, 0, 0);
    add(1, 0, HSIZE_WORD,  32'h2C, 32'h0,         K_NORM, 0, 0);
    add(2, 1, HSIZE_HWORD, 32'h32, 32'h4321_0000, K_NORM, 0, 0);
    add(1, 0, HSIZE_WORD,  32'h30, 32'h0,         K_NORM, 0, 0);
    add(2, 1, HSIZE_WORD,  32'h34, 32'h600D_D00D, K_NORM, 0, 0);
    add(0, 0, HSIZE_WORD,  32'h34, 32'h0,         K_NORM, 0, 0);
    // Transfers that must be ignored
    add(0, 1, HSIZE_WORD,  32'h38, 32'hDEAD_0001, K_IDLE,  0, 0);
    add(0, 1, HSIZE_WORD,  32'h38, 32'hDEAD_0002, K_BUSY,  0, 0);
    add(1, 1, HSIZE_WORD,  32'h3C, 32'hDEAD_0003, K_NOSEL, 0, 0);
    add(0, 0, HSIZE_WORD,  32'h38, 32'h0,         K_NORM,  0, 0);
    add(1, 0, HSIZE_WORD,  32'h3C, 32'h0,         K_NORM,  0, 0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int i;
    int last;
    seed    = 8646;
    n_ent   = 0;
    HRESETn = 1'b0;
    idle_port(0);
    idle_port(1);
    drive_wdata(0, 32'h0);
    drive_wdata(1, 32'h0);
    build_table();
    repeat (8) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    @(posedge HCLK);
    #1;
    i = 0;
    while (i < n_ent) begin
      if (tbl[i].kind != K_NORM) begin
        ignored_write(i);
      end else if (tbl[i].port == 2) begin
        dual_write(i);
      end else begin
        run_chain(i, last);
        i = last;
      end
      i++;
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/ahb_pkg.sv
common/mpram_pkg.sv
common/mpram_port_if.sv
mpram/ahb_port_ctrl.sv
mpram/mpram_core.sv
verilog/ahb_mpram_top.sv
sim/tb_ahb_mpram.sv

// ==== Makefile ====
# Verilator build and run for the dual-port AHB-Lite SRAM

VERILATOR ?= verilator
VFLAGS    := --binary --timing
TOP       := tb_ahb_mpram
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result, not the exit code of the binary
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Simulation PASSED" $(LOG); then \
	  echo "Log check ok"; \
	else \
	  echo "Log check found no pass line"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
